// File: common/rv_isa_pkg.sv
// rv64i execute encodings; only mstatus, mtvec, mepc and mcause have addresses here
`default_nettype none

package rv_isa_pkg;

  // data and field widths
  localparam int xlen       = 64;
  localparam int word_w     = 32;
  localparam int shamt_w    = $clog2(xlen);
  localparam int reg_addr_w = 5;
  localparam int csr_addr_w = 12;

  typedef enum logic [4:0] {
    alu_add    = 5'd0,
    alu_sub    = 5'd1,
    alu_sll    = 5'd2,
    alu_slt    = 5'd3,
    alu_sltu   = 5'd4,
    alu_xor    = 5'd5,
    alu_srl    = 5'd6,
    alu_sra    = 5'd7,
    alu_or     = 5'd8,
    alu_and    = 5'd9,
    alu_pass_b = 5'd10
  } alu_op_t;

  typedef enum logic {
    src1_rs1 = 1'b0,
    src1_pc  = 1'b1
  } src1_sel_t;

  typedef enum logic [1:0] {
    src2_rs2  = 2'd0,
    src2_imm  = 2'd1,
    src2_four = 2'd2
  } src2_sel_t;

  // ops ending in i take the zero-extended 5-bit immediate
  typedef enum logic [2:0] {
    csr_none = 3'd0,
    csr_rw   = 3'd1,
    csr_rs   = 3'd2,
    csr_rc   = 3'd3,
    csr_rwi  = 3'd4,
    csr_rsi  = 3'd5,
    csr_rci  = 3'd6
  } csr_op_t;

  localparam logic [csr_addr_w-1:0] csr_mstatus = 12'h300;
  localparam logic [csr_addr_w-1:0] csr_mtvec   = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mepc    = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause  = 12'h342;

endpackage

`default_nettype wire

// File: common/exu_pkg.sv
// records between decode, execute and writeback; field widths come from rv_isa_pkg
`default_nettype none

package exu_pkg;

  import rv_isa_pkg::*;

  // one decoded instruction as offered by the decoder
  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic                  rd_we;
    src1_sel_t             src1_sel;
    src2_sel_t             src2_sel;
    alu_op_t               alu_op;
    logic                  word_cut;
    logic [csr_addr_w-1:0] csr_addr;
    csr_op_t               csr_op;
    logic                  ebreak;
    logic                  invalid;
  } issue_t;

  // one committed result
  typedef struct packed {
    logic                  rd_we;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       rd_data;
    logic                  csr_we;
    logic [csr_addr_w-1:0] csr_addr;
    logic [xlen-1:0]       csr_wdata;
  } wb_t;

endpackage

`default_nettype wire

// File: exu/exu_alu.sv
// combinational 64-bit alu; word mode sign-extends bit 31 for every op, not only the w forms
`timescale 1ns/10ps
`default_nettype none

module exu_alu
  import rv_isa_pkg::*;
(
  input  wire logic [xlen-1:0] i_src_a,
  input  wire logic [xlen-1:0] i_src_b,
  input  wire alu_op_t         i_alu_op,
  input  wire logic            i_word_cut,
  output logic [xlen-1:0]      o_result
);

  logic [shamt_w-1:0] shamt;
  logic [word_w-1:0]  sll_w;
  logic [word_w-1:0]  srl_w;
  logic [word_w-1:0]  sra_w;
  logic [xlen-1:0]    raw;

  assign shamt = i_src_b[shamt_w-1:0];

  // word shifts use the low half of source a and a 5-bit amount
  assign sll_w = i_src_a[word_w-1:0] << shamt[4:0];
  assign srl_w = i_src_a[word_w-1:0] >> shamt[4:0];
  assign sra_w = $signed(i_src_a[word_w-1:0]) >>> shamt[4:0];

  always_comb begin
    case (i_alu_op)
      alu_add: begin
        raw = i_src_a + i_src_b;
      end
      alu_sub: begin
        raw = i_src_a - i_src_b;
      end
      alu_sll: begin
        raw = i_word_cut ? {{(xlen-word_w){1'b0}}, sll_w} : i_src_a << shamt;
      end
      alu_slt: begin
        raw = {{(xlen-1){1'b0}}, $signed(i_src_a) < $signed(i_src_b)};
      end
      alu_sltu: begin
        raw = {{(xlen-1){1'b0}}, i_src_a < i_src_b};
      end
      alu_xor: begin
        raw = i_src_a ^ i_src_b;
      end
      alu_srl: begin
        raw = i_word_cut ? {{(xlen-word_w){1'b0}}, srl_w} : i_src_a >> shamt;
      end
      alu_sra: begin
        // kept apart so the 64-bit shift stays signed
        if (i_word_cut) begin
          raw = {{(xlen-word_w){1'b0}}, sra_w};
        end else begin
          raw = $signed(i_src_a) >>> shamt;
        end
      end
      alu_or: begin
        raw = i_src_a | i_src_b;
      end
      alu_and: begin
        raw = i_src_a & i_src_b;
      end
      alu_pass_b: begin
        raw = i_src_b;
      end
      default: begin
        raw = '0;
      end
    endcase
  end

  // w forms keep the low word and extend its sign
  assign o_result = i_word_cut ? {{(xlen-word_w){raw[word_w-1]}}, raw[word_w-1:0]} : raw;

endmodule

`default_nettype wire

// File: exu/exu_csu.sv
// csr read-modify-write; csr_none passes the old value through unchanged
`timescale 1ns/10ps
`default_nettype none

module exu_csu
  import rv_isa_pkg::*;
(
  input  wire logic [xlen-1:0]       i_rs1data,
  input  wire logic [reg_addr_w-1:0] i_uimm,
  input  wire logic [xlen-1:0]       i_csr_rdata,
  input  wire csr_op_t               i_csr_op,
  output logic [xlen-1:0]            o_csr_wdata
);

  logic            use_uimm;
  logic [xlen-1:0] operand;

  assign use_uimm = (i_csr_op == csr_rwi) || (i_csr_op == csr_rsi) ||
                    (i_csr_op == csr_rci);

  assign operand = use_uimm ? {{(xlen-reg_addr_w){1'b0}}, i_uimm} : i_rs1data;

  always_comb begin
    case (i_csr_op)
      csr_rw, csr_rwi: begin
        o_csr_wdata = operand;
      end
      csr_rs, csr_rsi: begin
        o_csr_wdata = i_csr_rdata | operand;
      end
      csr_rc, csr_rci: begin
        o_csr_wdata = i_csr_rdata & ~operand;
      end
      default: begin
        o_csr_wdata = i_csr_rdata;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: exu/exu.sv
// execute for one instruction, combinational; word mode zero-extends rs1, rs2 and imm before the alu
`timescale 1ns/10ps
`default_nettype none

module exu
  import rv_isa_pkg::*;
  import exu_pkg::*;
(
  input  wire issue_t          i_issue,
  input  wire logic [xlen-1:0] i_rs1data,
  input  wire logic [xlen-1:0] i_rs2data,
  input  wire logic [xlen-1:0] i_csr_rdata,
  output logic [xlen-1:0]      o_alu_result,
  output logic [xlen-1:0]      o_csr_wdata,
  output logic                 o_ebreak,
  output logic                 o_invalid
);

  logic [xlen-1:0] rs1_op;
  logic [xlen-1:0] rs2_op;
  logic [xlen-1:0] imm_op;
  logic [xlen-1:0] src_a;
  logic [xlen-1:0] src_b;
  logic            has_csr;

  // cut to the low word for the w forms
  assign rs1_op = i_issue.word_cut ? {{(xlen-word_w){1'b0}}, i_rs1data[word_w-1:0]}
                                   : i_rs1data;
  assign rs2_op = i_issue.word_cut ? {{(xlen-word_w){1'b0}}, i_rs2data[word_w-1:0]}
                                   : i_rs2data;
  assign imm_op = i_issue.word_cut ? {{(xlen-word_w){1'b0}}, i_issue.imm[word_w-1:0]}
                                   : i_issue.imm;

  assign src_a = (i_issue.src1_sel == src1_pc) ? i_issue.pc : rs1_op;

  always_comb begin
    case (i_issue.src2_sel)
      src2_rs2:  src_b = rs2_op;
      src2_imm:  src_b = imm_op;
      src2_four: src_b = xlen'(4);
      default:   src_b = '0;
    endcase
  end

  exu_alu exu_alu_i (
    .i_src_a    (src_a),
    .i_src_b    (src_b),
    .i_alu_op   (i_issue.alu_op),
    .i_word_cut (i_issue.word_cut),
    .o_result   (o_alu_result)
  );

  // csr immediate sits in the rs1 field
  exu_csu exu_csu_i (
    .i_rs1data   (i_rs1data),
    .i_uimm      (i_issue.rs1),
    .i_csr_rdata (i_csr_rdata),
    .i_csr_op    (i_issue.csr_op),
    .o_csr_wdata (o_csr_wdata)
  );

  assign has_csr = (i_issue.csr_op != csr_none);

  // a trap flag together with a csr op is a broken decode
  assign o_ebreak  = i_issue.ebreak & ~has_csr;
  assign o_invalid = i_issue.invalid | (has_csr & i_issue.ebreak);

endmodule

`default_nettype wire

// File: hdl/gpr_file.sv
// 31 writable gprs, asynchronous reads; x0 reads zero and ignores writes
`timescale 1ns/10ps
`default_nettype none

module gpr_file
  import rv_isa_pkg::*;
(
  input  wire logic                  i_clk,
  input  wire logic                  i_rst,
  input  wire logic [reg_addr_w-1:0] i_raddr1,
  input  wire logic [reg_addr_w-1:0] i_raddr2,
  input  wire logic                  i_we,
  input  wire logic [reg_addr_w-1:0] i_waddr,
  input  wire logic [xlen-1:0]       i_wdata,
  output logic [xlen-1:0]            o_rdata1,
  output logic [xlen-1:0]            o_rdata2
);

  logic [xlen-1:0] regs [1:(2**reg_addr_w)-1];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no bypass, a write shows up after the edge
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

// File: hdl/csr_file.sv
// mstatus, mtvec, mepc and mcause only, all bits writable; other addresses read zero
`timescale 1ns/10ps
`default_nettype none

module csr_file
  import rv_isa_pkg::*;
(
  input  wire logic                  i_clk,
  input  wire logic                  i_rst,
  input  wire logic [csr_addr_w-1:0] i_raddr,
  input  wire logic                  i_we,
  input  wire logic [csr_addr_w-1:0] i_waddr,
  input  wire logic [xlen-1:0]       i_wdata,
  output logic [xlen-1:0]            o_rdata
);

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (i_we) begin
      case (i_waddr)
        csr_mstatus: mstatus <= i_wdata;
        csr_mtvec:   mtvec   <= i_wdata;
        csr_mepc:    mepc    <= i_wdata;
        csr_mcause:  mcause  <= i_wdata;
        default:     ;
      endcase
    end
  end

  always_comb begin
    case (i_raddr)
      csr_mstatus: o_rdata = mstatus;
      csr_mtvec:   o_rdata = mtvec;
      csr_mepc:    o_rdata = mepc;
      csr_mcause:  o_rdata = mcause;
      default:     o_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/exu_core.sv
// execute plus one writeback stage, no forwarding; leave one idle cycle before a dependent issue
`timescale 1ns/10ps
`default_nettype none

module exu_core
  import rv_isa_pkg::*;
  import exu_pkg::*;
(
  input  wire logic   i_clk,
  input  wire logic   i_rst,
  input  wire logic   i_issue_valid,
  input  wire issue_t i_issue,
  output logic        o_wb_valid,
  output wb_t         o_wb,
  output logic        o_halt,
  output logic        o_abort
);

  logic [xlen-1:0] rs1data;
  logic [xlen-1:0] rs2data;
  logic [xlen-1:0] csr_rdata;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] csr_wdata;
  logic            exu_ebreak;
  logic            exu_invalid;
  logic            accept;
  wb_t             wb_d;

  // commit side is the registered record
  gpr_file gpr_file_i (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_raddr1 (i_issue.rs1),
    .i_raddr2 (i_issue.rs2),
    .i_we     (o_wb_valid & o_wb.rd_we),
    .i_waddr  (o_wb.rd),
    .i_wdata  (o_wb.rd_data),
    .o_rdata1 (rs1data),
    .o_rdata2 (rs2data)
  );

  csr_file csr_file_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_raddr (i_issue.csr_addr),
    .i_we    (o_wb_valid & o_wb.csr_we),
    .i_waddr (o_wb.csr_addr),
    .i_wdata (o_wb.csr_wdata),
    .o_rdata (csr_rdata)
  );

  exu exu_i (
    .i_issue      (i_issue),
    .i_rs1data    (rs1data),
    .i_rs2data    (rs2data),
    .i_csr_rdata  (csr_rdata),
    .o_alu_result (alu_result),
    .o_csr_wdata  (csr_wdata),
    .o_ebreak     (exu_ebreak),
    .o_invalid    (exu_invalid)
  );

  // nothing enters once stopped
  assign accept = i_issue_valid & ~o_halt & ~o_abort;

  always_comb begin
    wb_d.rd_we     = i_issue.rd_we;
    wb_d.rd        = i_issue.rd;
    wb_d.csr_we    = (i_issue.csr_op != csr_none);
    wb_d.csr_addr  = i_issue.csr_addr;
    wb_d.csr_wdata = csr_wdata;
    // csr ops return the old value to rd
    wb_d.rd_data   = wb_d.csr_we ? csr_rdata : alu_result;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb_valid <= 1'b0;
      o_halt     <= 1'b0;
      o_abort    <= 1'b0;
    end else begin
      o_wb_valid <= accept;
      if (accept && exu_ebreak) begin
        o_halt <= 1'b1;
      end
      if (accept && exu_invalid) begin
        o_abort <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_wb <= wb_d;
    end
  end

endmodule

`default_nettype wire

// File: verif/exu_core_sva.sv
// bound into exu_core; checks writeback timing and the sticky stop flags, reset disables all checks
`timescale 1ns/10ps
`default_nettype none

module exu_core_sva (
  input wire logic i_clk,
  input wire logic i_rst,
  input wire logic i_issue_valid,
  input wire logic i_wb_valid,
  input wire logic i_halt,
  input wire logic i_abort
);

  // one cycle from issue to writeback while running
  wb_follows_issue: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (!i_halt && !i_abort) |=> (i_wb_valid == $past(i_issue_valid))
  ) else $error("writeback valid does not follow issue valid by one cycle");

  halt_sticky: assert property (
    @(posedge i_clk) disable iff (i_rst) !$fell(i_halt)
  ) else $error("halt flag fell without reset");

  abort_sticky: assert property (
    @(posedge i_clk) disable iff (i_rst) !$fell(i_abort)
  ) else $error("abort flag fell without reset");

  // the stopping instruction itself still writes back
  no_wb_after_stop: assert property (
    @(posedge i_clk) disable iff (i_rst)
    (i_halt || i_abort) |=> !i_wb_valid
  ) else $error("writeback seen after a stop flag was set");

endmodule

bind exu_core exu_core_sva exu_core_sva_i (
  .i_clk         (i_clk),
  .i_rst         (i_rst),
  .i_issue_valid (i_issue_valid),
  .i_wb_valid    (o_wb_valid),
  .i_halt        (o_halt),
  .i_abort       (o_abort)
);

`default_nettype wire

// File: verif/exu_core_tb.sv
// trace-driven testbench; run from the project root so verif/exu_trace.txt is found
`timescale 1ns/10ps
`default_nettype none

module exu_core_tb
  import rv_isa_pkg::*;
  import exu_pkg::*;
();

  localparam int wb_timeout = 8;

  logic        clk;
  logic        rst;
  logic        issue_valid;
  issue_t      issue;
  logic        wb_valid;
  wb_t         wb;
  logic        halt;
  logic        abort;
  int          fd;
  int          n_checks;
  string       line;
  string       name;
  string       kind;
  logic [63:0] fld [0:22];

  exu_core exu_core_i (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_issue_valid (issue_valid),
    .i_issue       (issue),
    .o_wb_valid    (wb_valid),
    .o_wb          (wb),
    .o_halt        (halt),
    .o_abort       (abort)
  );

  always #20 clk = ~clk;

  task automatic report_fail(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  // inputs change 2 ns after the edge, outputs are sampled there too
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    issue_valid = 1'b0;
    repeat (3) tick();
    rst = 1'b0;
  endtask

  task automatic check_wb(input string tname, input wb_t exp_wb, input wb_t act_wb);
    n_checks++;
    if (act_wb !== exp_wb) begin
      report_fail($sformatf("FAILED %s wb expected %h actual %h", tname, exp_wb, act_wb));
    end
  endtask

  task automatic check_flags(input string tname, input logic [1:0] exp_f,
                             input logic [1:0] act_f);
    n_checks++;
    if (act_f !== exp_f) begin
      report_fail($sformatf("FAILED %s halt/abort expected %b actual %b", tname, exp_f, act_f));
    end
  endtask

  task automatic wait_wb(input string tname);
    int n;
    n = 0;
    while (!wb_valid && n < wb_timeout) begin
      tick();
      n++;
    end
    if (!wb_valid) begin
      report_fail($sformatf("no writeback for %s within %0d cycles", tname, wb_timeout));
    end else if (n != 0) begin
      report_fail($sformatf("writeback for %s came %0d cycles late", tname, n));
    end
  endtask

  task automatic run_issue();
    issue_t iss;
    wb_t    exp_wb;
    int     n;
    n = $sscanf(line,
      "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
      name, kind, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
      fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
      fld[15], fld[16], fld[17], fld[18], fld[19], fld[20], fld[21], fld[22]);
    if (n != 25) begin
      report_fail($sformatf("malformed trace record for %s", name));
    end
    iss.pc       = fld[0];
    iss.imm      = fld[1];
    iss.rs1      = fld[2][reg_addr_w-1:0];
    iss.rs2      = fld[3][reg_addr_w-1:0];
    iss.rd       = fld[4][reg_addr_w-1:0];
    iss.rd_we    = fld[5][0];
    iss.src1_sel = src1_sel_t'(fld[6][0]);
    iss.src2_sel = src2_sel_t'(fld[7][1:0]);
    iss.alu_op   = alu_op_t'(fld[8][4:0]);
    iss.word_cut = fld[9][0];
    iss.csr_addr = fld[10][csr_addr_w-1:0];
    iss.csr_op   = csr_op_t'(fld[11][2:0]);
    iss.ebreak   = fld[12][0];
    iss.invalid  = fld[13][0];
    exp_wb.rd_we     = fld[15][0];
    exp_wb.rd        = fld[16][reg_addr_w-1:0];
    exp_wb.rd_data   = fld[17];
    exp_wb.csr_we    = fld[18][0];
    exp_wb.csr_addr  = fld[19][csr_addr_w-1:0];
    exp_wb.csr_wdata = fld[20];
    issue = iss;
    issue_valid = 1'b1;
    tick();
    issue_valid = 1'b0;
    if (fld[14][0]) begin
      wait_wb(name);
      check_wb(name, exp_wb, wb);
    end else if (wb_valid) begin
      report_fail($sformatf("unexpected writeback for %s after a stop flag", name));
    end
    check_flags(name, {fld[21][0], fld[22][0]}, {halt, abort});
  endtask

  task automatic run_line();
    case (kind)
      "i": run_issue();
      "w": tick();
      "r": apply_reset();
      default: report_fail($sformatf("unknown record kind %s in %s", kind, name));
    endcase
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    issue_valid = 1'b0;
    issue = '0;
    n_checks = 0;
    apply_reset();
    fd = $fopen("verif/exu_trace.txt", "r");
    if (fd == 0) begin
      report_fail("cannot open verif/exu_trace.txt");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
        if ($sscanf(line, "%s %s", name, kind) == 2) begin
          run_line();
        end
      end
    end
    $fclose(fd);
    tick();
    if (n_checks == 0) begin
      report_fail("the trace held no issue records");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verif/exu_trace.txt
# name kind(i issue, w idle, r reset) pc imm rs1 rs2 rd rd_we src1 src2 alu word csr_addr csr_op ebreak invalid
# then: expect rd_we rd rd_data csr_we csr_addr csr_wdata halt abort (all hex)
li_x1     i 0 7ff0 0 0 1 1 0 1 a 0 0 0 0 0  1 1 1 7ff0 0 0 0 0 0
li_x2     i 0 ffffffffffff0003 0 0 2 1 0 1 a 0 0 0 0 0  1 1 2 ffffffffffff0003 0 0 0 0 0
gap_1     w
add_rr    i 0 0 1 2 4 1 0 0 0 0 0 0 0 0  1 1 4 ffffffffffff7ff3 0 0 0 0 0
sub_rr    i 0 0 1 2 5 1 0 0 1 0 0 0 0 0  1 1 5 17fed 0 0 0 0 0
sll_imm   i 0 4 1 0 6 1 0 1 2 0 0 0 0 0  1 1 6 7ff00 0 0 0 0 0
slt_rr    i 0 0 2 1 7 1 0 0 3 0 0 0 0 0  1 1 7 1 0 0 0 0 0
sltu_rr   i 0 0 2 1 8 1 0 0 4 0 0 0 0 0  1 1 8 0 0 0 0 0 0
xor_imm   i 0 ff 1 0 9 1 0 1 5 0 0 0 0 0  1 1 9 7f0f 0 0 0 0 0
srl_rr    i 0 0 2 1 a 1 0 0 6 0 0 0 0 0  1 1 a ffff 0 0 0 0 0
sra_rr    i 0 0 2 1 b 1 0 0 7 0 0 0 0 0  1 1 b ffffffffffffffff 0 0 0 0 0
or_four   i 0 0 1 0 c 1 0 2 8 0 0 0 0 0  1 1 c 7ff4 0 0 0 0 0
and_imm   i 0 ff0 1 0 d 1 0 1 9 0 0 0 0 0  1 1 d ff0 0 0 0 0 0
addiw     i 0 7fff8010 1 0 e 1 0 1 0 1 0 0 0 0  1 1 e ffffffff80000000 0 0 0 0 0
sub_word  i 0 80000000 1 0 f 1 0 1 1 1 0 0 0 0  1 1 f ffffffff80007ff0 0 0 0 0 0
sraw_imm  i 0 3 2 0 10 1 0 1 7 1 0 0 0 0  1 1 10 ffffffffffffe000 0 0 0 0 0
srlw_rr   i 0 0 2 1 11 1 0 0 6 1 0 0 0 0  1 1 11 ffff 0 0 0 0 0
auipc     i 1000 5000 0 0 12 1 1 1 0 0 0 0 0 0  1 1 12 6000 0 0 0 0 0
pc_plus4  i 2000 0 0 0 13 1 1 2 0 0 0 0 0 0  1 1 13 2004 0 0 0 0 0
x0_write  i 0 55 0 0 0 1 0 1 a 0 0 0 0 0  1 1 0 55 0 0 0 0 0
gap_2     w
x0_read   i 0 0 0 5 14 1 0 0 0 0 0 0 0 0  1 1 14 17fed 0 0 0 0 0
csrrw     i 0 0 1 0 15 1 0 0 0 0 305 1 0 0  1 1 15 0 1 305 7ff0 0 0
csrrsi    i 0 0 1a 0 16 1 0 0 0 0 300 5 0 0  1 1 16 0 1 300 1a 0 0
csrrwi    i 0 0 1f 0 17 1 0 0 0 0 341 4 0 0  1 1 17 0 1 341 1f 0 0
csrrs     i 0 0 6 0 18 1 0 0 0 0 342 2 0 0  1 1 18 0 1 342 7ff00 0 0
gap_3     w
csrrc     i 0 0 9 0 19 1 0 0 0 0 305 3 0 0  1 1 19 7ff0 1 305 f0 0 0
csrrci    i 0 0 a 0 1a 1 0 0 0 0 300 6 0 0  1 1 1a 1a 1 300 10 0 0
gap_4     w
rd_mtvec  i 0 0 0 0 1b 1 0 0 0 0 305 2 0 0  1 1 1b f0 1 305 f0 0 0
rd_mstat  i 0 0 0 0 1c 1 0 0 0 0 300 5 0 0  1 1 1c 10 1 300 10 0 0
ebreak    i 0 0 0 0 0 0 0 0 0 0 0 0 1 0  1 0 0 0 0 0 0 1 0
halted    i 0 99 0 0 1 1 0 1 a 0 0 0 0 0  0 0 0 0 0 0 0 1 0
reset_1   r
after_rst i 0 0 1 0 2 1 0 0 0 0 0 0 0 0  1 1 2 0 0 0 0 0 0
invalid   i 0 0 0 0 0 0 0 0 0 0 0 0 0 1  1 0 0 0 0 0 0 0 1
aborted   i 0 77 0 0 3 1 0 1 a 0 0 0 0 0  0 0 0 0 0 0 0 0 1

// File: vlog.f
common/rv_isa_pkg.sv
common/exu_pkg.sv
exu/exu_alu.sv
exu/exu_csu.sv
exu/exu.sv
hdl/gpr_file.sv
hdl/csr_file.sv
hdl/exu_core.sv
verif/exu_core_sva.sv
verif/exu_core_tb.sv

// File: Bender.yml
package:
  name: exu_core

sources:
  - common/rv_isa_pkg.sv
  - common/exu_pkg.sv
  - exu/exu_alu.sv
  - exu/exu_csu.sv
  - exu/exu.sv
  - hdl/gpr_file.sv
  - hdl/csr_file.sv
  - hdl/exu_core.sv
  - target: test
    files:
      - verif/exu_core_sva.sv
      - verif/exu_core_tb.sv
